// File: Makefile
VERILATOR ?= verilator
TOP       ?= vector_mul_tb
FILELIST  ?= vector_mul_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
COMMON    ?= --timing --assert --timescale 1ns/1ps
VFLAGS    ?= --binary -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(COMMON) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only $(COMMON) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/lane_multiplier.sv
`timescale 1ns/1ps

`include "mul_config.svh"

module lane_multiplier (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic [`MUL_XLEN-1:0] multiplicand,
  input  logic [`MUL_XLEN-1:0] multiplier,
  input  logic [1:0]           is_signed,
  mul_step_if.mulr             ctl,
  output logic [`MUL_PLEN-1:0] product
);

  // operand signs and magnitudes
  logic                 a_neg;
  logic                 b_neg;
  logic [`MUL_XLEN-1:0] a_mag;
  logic [`MUL_XLEN-1:0] b_mag;

  // running sum and shift registers
  logic [`MUL_PLEN-1:0] acc;
  logic [`MUL_PLEN-1:0] mcand_sh;
  logic [`MUL_XLEN-1:0] mplier_sh;
  logic                 neg;

  // bit 1 is multiplicand sign enable, bit 0 multiplier
  assign a_neg = is_signed[1] & multiplicand[`MUL_XLEN-1];
  assign b_neg = is_signed[0] & multiplier[`MUL_XLEN-1];

  // most negative value maps to 2^31, still fits unsigned
  assign a_mag = a_neg ? -multiplicand : multiplicand;
  assign b_mag = b_neg ? -multiplier : multiplier;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      acc <= '0;
      neg <= 1'b0;
    end else if (ctl.load) begin
      acc <= '0;
      // result sign remembered for the end
      neg <= a_neg ^ b_neg;
    end else if (ctl.step && mplier_sh[0]) begin
      acc <= acc + mcand_sh;
    end
  end

  always_ff @(posedge CLK) begin
    if (ctl.load) begin
      mcand_sh  <= {{(`MUL_PLEN - `MUL_XLEN){1'b0}}, a_mag};
      mplier_sh <= b_mag;
    end else if (ctl.step) begin
      // next multiplier bit, multiplicand weight doubles
      mcand_sh  <= mcand_sh << 1;
      mplier_sh <= mplier_sh >> 1;
    end
  end

  // sign restored on the magnitude product
  assign product = neg ? -acc : acc;

endmodule

// File: source/mul_config.svh
`ifndef MUL_CONFIG_SVH
`define MUL_CONFIG_SVH

// element register width
`define MUL_XLEN 32

// full product width, twice the element register
`define MUL_PLEN 64

// one multiplier bit per step
`define MUL_STEPS 32

`endif

// File: source/mul_ctrl_pkg.sv
package mul_ctrl_pkg;

  // sequencer states
  // load captures operands, run steps the multiplier
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    LOAD   = 2'b01,
    RUN    = 2'b10,
    FINISH = 2'b11
  } seq_state_t;

endpackage

// File: source/mul_sequencer.sv
`timescale 1ns/1ps

`include "mul_config.svh"

module mul_sequencer (
  input  logic   CLK,
  input  logic   nRST,
  input  logic   start,
  input  logic   flush,
  output logic   busy,
  output logic   done,
  mul_step_if.seq ctl
);

  mul_ctrl_pkg::seq_state_t state, next_state;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= mul_ctrl_pkg::IDLE;
      done  <= 1'b0;
    end else begin
      state <= next_state;
      // done registered on entry to finish
      done  <= (next_state == mul_ctrl_pkg::FINISH);
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      mul_ctrl_pkg::IDLE: begin
        // start taken only when idle and not flushed
        if (start && !flush) next_state = mul_ctrl_pkg::LOAD;
      end
      mul_ctrl_pkg::LOAD: begin
        if (flush) next_state = mul_ctrl_pkg::IDLE;
        else next_state = mul_ctrl_pkg::RUN;
      end
      mul_ctrl_pkg::RUN: begin
        // flush beats last step, no done
        if (flush) next_state = mul_ctrl_pkg::IDLE;
        else if (ctl.last_step) next_state = mul_ctrl_pkg::FINISH;
      end
      default: begin
        next_state = mul_ctrl_pkg::IDLE;
      end
    endcase
  end

  // control decoded straight from state
  assign ctl.load   = (state == mul_ctrl_pkg::LOAD);
  assign ctl.step   = (state == mul_ctrl_pkg::RUN);
  assign ctl.finish = (state == mul_ctrl_pkg::FINISH);
  assign busy       = (state != mul_ctrl_pkg::IDLE);

  // load to finish spans every multiplier step
  a_run_length: assert property (@(posedge CLK) disable iff (!nRST)
    ctl.finish |-> $past(ctl.load, `MUL_STEPS + 1));

endmodule

// File: source/mul_step_counter.sv
`timescale 1ns/1ps

`include "mul_config.svh"

module mul_step_counter (
  input logic     CLK,
  input logic     nRST,
  mul_step_if.cnt cnt
);

  localparam int CW = $clog2(`MUL_STEPS);

  logic [CW-1:0] count;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else if (cnt.load) begin
      count <= '0;
    end else if (cnt.step) begin
      // wraps to zero after the final step
      count <= count + 1'b1;
    end
  end

  // final step flag
  assign cnt.last_step = (count == CW'(`MUL_STEPS - 1));

  // no extra step once the last one has run
  a_no_step_past_last: assert property (@(posedge CLK) disable iff (!nRST)
    (cnt.step && cnt.last_step) |=> !cnt.step);

endmodule

// File: source/mul_step_if.sv
`timescale 1ns/1ps

interface mul_step_if;

  // one cycle pulse, operands captured
  logic load;

  // high through every run cycle
  logic step;

  // count has reached the final step
  logic last_step;

  // one cycle pulse, result ready
  logic finish;

  // state machine
  modport seq (
    output load, step, finish,
    input  last_step
  );

  // step counter
  modport cnt (
    input  load, step,
    output last_step
  );

  // shift-and-add datapath
  modport mulr (
    input load, step
  );

  // decode and result path
  modport dp (
    input load, finish
  );

endinterface

// File: source/multiply_unit.sv
`timescale 1ns/1ps

`include "mul_config.svh"

module multiply_unit (
  input  logic                      CLK,
  input  logic                      nRST,
  input  vector_types_pkg::mul_op_t op,
  input  vector_types_pkg::sew_t    sew,
  input  logic [`MUL_XLEN-1:0]      vs1_data,
  input  logic [`MUL_XLEN-1:0]      vs2_data,
  input  logic [`MUL_XLEN-1:0]      vs3_data,
  mul_step_if.dp                    ctl,
  input  logic [`MUL_PLEN-1:0]      product,
  output logic [`MUL_XLEN-1:0]      ext_vs1,
  output logic [`MUL_XLEN-1:0]      ext_vs2,
  output logic [1:0]                is_signed,
  output logic [`MUL_XLEN-1:0]      wdata
);

  vector_types_pkg::mul_op_t op_q;
  vector_types_pkg::sew_t    sew_q;
  logic [`MUL_XLEN-1:0]      vs3_q;
  logic [`MUL_XLEN-1:0]      field;
  logic [`MUL_XLEN-1:0]      result;
  logic [`MUL_XLEN-1:0]      wdata_q;
  logic                      armed;
  logic                      high_sel;
  logic                      widen;
  logic                      accum;
  logic                      negate;

  // element in the low bits, upper bits sign or zero filled
  function automatic logic [`MUL_XLEN-1:0] extend(input logic [`MUL_XLEN-1:0] d,
                                                  input vector_types_pkg::sew_t w,
                                                  input logic sgn);
    logic [`MUL_XLEN-1:0] r;
    case (w)
      vector_types_pkg::SEW8:  r = {{(`MUL_XLEN - 8){sgn & d[7]}}, d[7:0]};
      vector_types_pkg::SEW16: r = {{(`MUL_XLEN - 16){sgn & d[15]}}, d[15:0]};
      default:                 r = d;
    endcase
    return r;
  endfunction

  // signedness from live op, multiplier samples it on load
  always_comb begin
    case (op)
      vector_types_pkg::VMULHU,
      vector_types_pkg::VWMULU:  is_signed = 2'b00;
      vector_types_pkg::VMULHSU: is_signed = 2'b10;
      default:                   is_signed = 2'b11;
    endcase
  end

  assign ext_vs1 = extend(vs1_data, sew, is_signed[0]);
  assign ext_vs2 = extend(vs2_data, sew, is_signed[1]);

  // op, width and addend held for the whole operation
  always_ff @(posedge CLK) begin
    if (ctl.load) begin
      op_q  <= op;
      sew_q <= sew;
      vs3_q <= vs3_data;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      armed <= 1'b0;
    end else if (ctl.load) begin
      armed <= 1'b1;
    end else if (ctl.finish) begin
      armed <= 1'b0;
    end
  end

  // result decode from latched op
  assign high_sel = (op_q == vector_types_pkg::VMULH) || (op_q == vector_types_pkg::VMULHU) ||
                    (op_q == vector_types_pkg::VMULHSU);
  assign widen    = (op_q == vector_types_pkg::VWMUL) || (op_q == vector_types_pkg::VWMULU);
  assign accum    = (op_q == vector_types_pkg::VMACC) || (op_q == vector_types_pkg::VNMSAC);
  assign negate   = (op_q == vector_types_pkg::VNMSAC);

  always_comb begin
    case (sew_q)
      vector_types_pkg::SEW8:
        field = high_sel ? {24'b0, product[15:8]} : {24'b0, product[7:0]};
      vector_types_pkg::SEW16:
        field = high_sel ? {16'b0, product[31:16]} : {16'b0, product[15:0]};
      default:
        field = high_sel ? product[63:32] : product[31:0];
    endcase
    // widened result is the double width element
    if (widen) field = product[31:0];
    if (accum) result = negate ? (vs3_q - field) : (vs3_q + field);
    else result = field;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wdata_q <= '0;
    end else if (ctl.finish && armed) begin
      wdata_q <= result;
    end
  end

  // result forwarded during finish, then held
  assign wdata = ctl.finish ? result : wdata_q;

  a_finish_after_load: assert property (@(posedge CLK) disable iff (!nRST)
    ctl.finish |-> armed);

endmodule

// File: source/vector_mul_top.sv
`timescale 1ns/1ps

`include "mul_config.svh"

module vector_mul_top (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      start,
  input  logic                      flush,
  input  vector_types_pkg::mul_op_t op,
  input  vector_types_pkg::sew_t    sew,
  input  logic [`MUL_XLEN-1:0]      vs1_data,
  input  logic [`MUL_XLEN-1:0]      vs2_data,
  input  logic [`MUL_XLEN-1:0]      vs3_data,
  output logic                      busy,
  output logic                      done,
  output logic [`MUL_XLEN-1:0]      wdata
);

  logic [`MUL_XLEN-1:0] ext_vs1;
  logic [`MUL_XLEN-1:0] ext_vs2;
  logic [1:0]           is_signed;
  logic [`MUL_PLEN-1:0] product;

  // step control shared by sequencer, counter, datapath
  mul_step_if step_if ();

  mul_sequencer seq_i (.CLK(CLK), .nRST(nRST), .start(start), .flush(flush),
                       .busy(busy), .done(done), .ctl(step_if.seq));

  mul_step_counter cnt_i (.CLK(CLK), .nRST(nRST), .cnt(step_if.cnt));

  // vs2 is multiplicand, vs1 multiplier
  lane_multiplier mul_i (.CLK(CLK), .nRST(nRST), .multiplicand(ext_vs2),
                         .multiplier(ext_vs1), .is_signed(is_signed),
                         .ctl(step_if.mulr), .product(product));

  multiply_unit mu_i (.CLK(CLK), .nRST(nRST), .op(op), .sew(sew),
                      .vs1_data(vs1_data), .vs2_data(vs2_data), .vs3_data(vs3_data),
                      .ctl(step_if.dp), .product(product),
                      .ext_vs1(ext_vs1), .ext_vs2(ext_vs2),
                      .is_signed(is_signed), .wdata(wdata));

endmodule

// File: source/vector_types_pkg.sv
package vector_types_pkg;

  // selected element width
  typedef enum logic [1:0] {
    SEW8  = 2'b00,
    SEW16 = 2'b01,
    SEW32 = 2'b10
  } sew_t;

  // multiply opcodes
  // high variants differ only in operand signedness
  typedef enum logic [2:0] {
    VMUL    = 3'b000,
    VMULH   = 3'b001,
    VMULHU  = 3'b010,
    VMULHSU = 3'b011,
    VMACC   = 3'b100,
    VNMSAC  = 3'b101,
    VWMUL   = 3'b110,
    VWMULU  = 3'b111
  } mul_op_t;

endpackage

// File: vector_mul_top.f
+incdir+source
source/vector_types_pkg.sv
source/mul_ctrl_pkg.sv
source/mul_step_if.sv
source/mul_sequencer.sv
source/mul_step_counter.sv
source/lane_multiplier.sv
source/multiply_unit.sv
source/vector_mul_top.sv
verif/vector_mul_tb.sv

// File: verif/vector_mul_tb.sv
`timescale 1ns/1ps

`include "mul_config.svh"

module vector_mul_tb;

  // random, corner, then restart, flush and recovery ops
  localparam int NUM_OPS  = 8 * 3 * 3 + 8 * 3 * 16 + 3;
  localparam int LIMIT_NS = NUM_OPS * 40 * 8 + 2000;

  logic                      CLK;
  logic                      nRST;
  logic                      start;
  logic                      flush;
  vector_types_pkg::mul_op_t op;
  vector_types_pkg::sew_t    sew;
  logic [`MUL_XLEN-1:0]      vs1_data;
  logic [`MUL_XLEN-1:0]      vs2_data;
  logic [`MUL_XLEN-1:0]      vs3_data;
  logic                      busy;
  logic                      done;
  logic [`MUL_XLEN-1:0]      wdata;

  // expected outputs, from start/flush and the fixed latency
  logic                      exp_busy;
  logic                      exp_done;
  logic [`MUL_XLEN-1:0]      exp_wdata;
  int                        phase;
  integer                    seed;

  vector_mul_top uut (
    .CLK(CLK), .nRST(nRST), .start(start), .flush(flush), .op(op), .sew(sew),
    .vs1_data(vs1_data), .vs2_data(vs2_data), .vs3_data(vs3_data),
    .busy(busy), .done(done), .wdata(wdata)
  );

  always #4 CLK = ~CLK;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    stop_on_error($sformatf("Fail at %0t: %s expected %h actual %h", $time, name,
                            expected, actual));
  endtask

  function automatic int element_bits(input vector_types_pkg::sew_t w);
    case (w)
      vector_types_pkg::SEW8:  return 8;
      vector_types_pkg::SEW16: return 16;
      default:                 return 32;
    endcase
  endfunction

  // result rules: extend, full product, field by sew, widen, accumulate
  function automatic logic [31:0] expected_wdata(input vector_types_pkg::mul_op_t o,
                                                 input vector_types_pkg::sew_t w,
                                                 input logic [31:0] v1, input logic [31:0] v2,
                                                 input logic [31:0] v3);
    int          width;
    logic        sgn1;
    logic        sgn2;
    logic [63:0] mask;
    logic [63:0] msb;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] full;
    logic [31:0] field;
    width = element_bits(w);
    // vs2 unsigned only for the fully unsigned ops, vs1 also for hsu
    sgn2  = !(o == vector_types_pkg::VMULHU || o == vector_types_pkg::VWMULU);
    sgn1  = sgn2 && (o != vector_types_pkg::VMULHSU);
    mask  = (64'd1 << width) - 64'd1;
    msb   = mask & ~(mask >> 1);
    a     = {32'b0, v2} & mask;
    b     = {32'b0, v1} & mask;
    if (sgn2 && (a & msb) != 64'd0) a = a | ~mask;
    if (sgn1 && (b & msb) != 64'd0) b = b | ~mask;
    // low 64 bits are exact for any sign mix
    full = a * b;
    case (o)
      vector_types_pkg::VMULH, vector_types_pkg::VMULHU, vector_types_pkg::VMULHSU:
        field = 32'((full >> width) & mask);
      vector_types_pkg::VWMUL, vector_types_pkg::VWMULU:
        field = full[31:0];
      default:
        field = 32'(full & mask);
    endcase
    case (o)
      vector_types_pkg::VMACC:  return v3 + field;
      vector_types_pkg::VNMSAC: return v3 - field;
      default:                  return field;
    endcase
  endfunction

  // zero, all ones, most negative, most positive at the element width
  function automatic logic [31:0] corner_value(input int idx, input vector_types_pkg::sew_t w);
    logic [31:0] top;
    top = 32'd1 << (element_bits(w) - 1);
    case (idx)
      0:       return 32'd0;
      1:       return 32'hffff_ffff;
      2:       return top;
      default: return top - 32'd1;
    endcase
  endfunction

  // idle, 1 load cycle, run cycles, then finish with done
  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      exp_busy <= 1'b0;
      exp_done <= 1'b0;
      phase    <= 0;
    end else if (phase == 0) begin
      if (start && !flush) begin
        exp_busy <= 1'b1;
        phase    <= 1;
      end
    end else if (flush && phase < `MUL_STEPS + 2) begin
      // abandoned before finish, no done
      exp_busy <= 1'b0;
      phase    <= 0;
    end else if (phase == `MUL_STEPS + 1) begin
      exp_done <= 1'b1;
      phase    <= `MUL_STEPS + 2;
    end else if (phase == `MUL_STEPS + 2) begin
      exp_busy <= 1'b0;
      exp_done <= 1'b0;
      phase    <= 0;
    end else begin
      phase <= phase + 1;
    end
  end

  a_busy: assert property (@(posedge CLK) disable iff (!nRST) busy == exp_busy)
    else report_mismatch("busy", 32'($sampled(exp_busy)), 32'($sampled(busy)));

  a_done: assert property (@(posedge CLK) disable iff (!nRST) done == exp_done)
    else report_mismatch("done", 32'($sampled(exp_done)), 32'($sampled(done)));

  a_wdata: assert property (@(posedge CLK) disable iff (!nRST) done |-> wdata == exp_wdata)
    else report_mismatch("wdata", $sampled(exp_wdata), $sampled(wdata));

  // start pulse, then hold operands until busy drops
  task automatic issue_op(input vector_types_pkg::mul_op_t o, input vector_types_pkg::sew_t w,
                          input logic [31:0] a1, input logic [31:0] a2, input logic [31:0] a3,
                          input int flush_at, input int restart_at);
    int cyc;
    exp_wdata = expected_wdata(o, w, a1, a2, a3);
    op        = o;
    sew       = w;
    vs1_data  = a1;
    vs2_data  = a2;
    vs3_data  = a3;
    start     = 1'b1;
    @(posedge CLK);
    #1;
    start = 1'b0;
    cyc   = 1;
    while (busy) begin
      if (cyc == restart_at) begin
        // new operands and start mid run, must be dropped
        op       = vector_types_pkg::VWMULU;
        vs1_data = $random(seed);
        vs2_data = $random(seed);
        vs3_data = $random(seed);
        start    = 1'b1;
      end
      if (cyc == flush_at) flush = 1'b1;
      @(posedge CLK);
      #1;
      start = 1'b0;
      flush = 1'b0;
      cyc   = cyc + 1;
    end
  endtask

  initial begin
    seed      = 49257;
    CLK       = 1'b0;
    nRST      = 1'b0;
    start     = 1'b0;
    flush     = 1'b0;
    op        = vector_types_pkg::VMUL;
    sew       = vector_types_pkg::SEW8;
    vs1_data  = '0;
    vs2_data  = '0;
    vs3_data  = '0;
    exp_wdata = '0;
    repeat (2) @(posedge CLK);
    #1;
    nRST = 1'b1;
    // quiet stretch after reset
    repeat (4) @(posedge CLK);
    #1;
    for (int o = 0; o < 8; o++) begin
      for (int w = 0; w < 3; w++) begin
        repeat (3) begin
          issue_op(vector_types_pkg::mul_op_t'(o), vector_types_pkg::sew_t'(w),
                   $random(seed), $random(seed), $random(seed), 0, 0);
        end
        // every pairing of the four corner operands
        for (int i = 0; i < 16; i++) begin
          issue_op(vector_types_pkg::mul_op_t'(o), vector_types_pkg::sew_t'(w),
                   corner_value(i % 4, vector_types_pkg::sew_t'(w)),
                   corner_value(i / 4, vector_types_pkg::sew_t'(w)), $random(seed), 0, 0);
        end
      end
    end
    issue_op(vector_types_pkg::VMULH, vector_types_pkg::SEW32,
             $random(seed), $random(seed), $random(seed), 0, 10);
    // no second done may follow
    repeat (4) @(posedge CLK);
    #1;
    issue_op(vector_types_pkg::VMACC, vector_types_pkg::SEW16,
             $random(seed), $random(seed), $random(seed), 12, 0);
    issue_op(vector_types_pkg::VNMSAC, vector_types_pkg::SEW8,
             $random(seed), $random(seed), $random(seed), 0, 0);
    repeat (3) @(posedge CLK);
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin
    #(LIMIT_NS);
    stop_on_error("watchdog expired before all operations completed");
  end

endmodule
